//--- rtl/udp_tx_params.svh
`ifndef UDP_TX_PARAMS_SVH
`define UDP_TX_PARAMS_SVH

// payload buffering
`define UDP_TX_FIFO_DEPTH 2048
`define UDP_TX_LEN_W 11

// frame layout in bytes
`define UDP_TX_PREAMBLE_BYTES 7
`define UDP_TX_GAP_BYTES 12
`define UDP_TX_HDR_BYTES 42

`define UDP_TX_TTL 8'd64

// apb register map, word addresses
`define UDP_TX_REG_LOCAL_MAC_LO 6'h00
`define UDP_TX_REG_LOCAL_MAC_HI 6'h01
`define UDP_TX_REG_LOCAL_IP 6'h02
`define UDP_TX_REG_LOCAL_PORT 6'h03
`define UDP_TX_REG_HOST_MAC_LO 6'h04
`define UDP_TX_REG_HOST_MAC_HI 6'h05
`define UDP_TX_REG_HOST_IP 6'h06
`define UDP_TX_REG_HOST_PORT 6'h07
`define UDP_TX_REG_PAYLOAD_LEN 6'h08

`endif

//--- rtl/udp_tx_pkg.sv
`include "udp_tx_params.svh"

package udp_tx_pkg;

    // wire order, first field goes out first
    typedef struct packed {
        // ethernet
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        // ipv4
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] id;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] ip_checksum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        // udp
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_checksum;
    } eth_udp_header_t;

    typedef struct packed {
        logic [47:0]              local_mac;
        logic [31:0]              local_ip;
        logic [15:0]              local_port;
        logic [47:0]              host_mac;
        logic [31:0]              host_ip;
        logic [15:0]              host_port;
        logic [`UDP_TX_LEN_W-1:0] payload_len;
    } udp_tx_cfg_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [5:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage

//--- rtl/udp_cfg_regs.sv
`include "udp_tx_params.svh"

module udp_cfg_regs
    import udp_tx_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  apb_req_t    apb_req_i,
    output apb_rsp_t    apb_rsp_o,
    output udp_tx_cfg_t cfg_o
);

    udp_tx_cfg_t cfg_q;
    logic        access;
    logic        addr_hit;
    logic [31:0] rdata;

    // second cycle of a transfer
    assign access = apb_req_i.psel && apb_req_i.penable;

    always_comb begin
        addr_hit = 1'b1;
        rdata    = '0;
        case (apb_req_i.paddr)
            `UDP_TX_REG_LOCAL_MAC_LO: rdata = cfg_q.local_mac[31:0];
            `UDP_TX_REG_LOCAL_MAC_HI: rdata = {16'h0000, cfg_q.local_mac[47:32]};
            `UDP_TX_REG_LOCAL_IP:     rdata = cfg_q.local_ip;
            `UDP_TX_REG_LOCAL_PORT:   rdata = {16'h0000, cfg_q.local_port};
            `UDP_TX_REG_HOST_MAC_LO:  rdata = cfg_q.host_mac[31:0];
            `UDP_TX_REG_HOST_MAC_HI:  rdata = {16'h0000, cfg_q.host_mac[47:32]};
            `UDP_TX_REG_HOST_IP:      rdata = cfg_q.host_ip;
            `UDP_TX_REG_HOST_PORT:    rdata = {16'h0000, cfg_q.host_port};
            `UDP_TX_REG_PAYLOAD_LEN: begin
                rdata = {{(32 - `UDP_TX_LEN_W){1'b0}}, cfg_q.payload_len};
            end
            default: addr_hit = 1'b0;
        endcase
    end

    // narrow registers keep only their low bits
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_q <= '0;
        end else if (access && apb_req_i.pwrite && addr_hit) begin
            case (apb_req_i.paddr)
                `UDP_TX_REG_LOCAL_MAC_LO: cfg_q.local_mac[31:0]  <= apb_req_i.pwdata;
                `UDP_TX_REG_LOCAL_MAC_HI: cfg_q.local_mac[47:32] <= apb_req_i.pwdata[15:0];
                `UDP_TX_REG_LOCAL_IP:     cfg_q.local_ip         <= apb_req_i.pwdata;
                `UDP_TX_REG_LOCAL_PORT:   cfg_q.local_port       <= apb_req_i.pwdata[15:0];
                `UDP_TX_REG_HOST_MAC_LO:  cfg_q.host_mac[31:0]   <= apb_req_i.pwdata;
                `UDP_TX_REG_HOST_MAC_HI:  cfg_q.host_mac[47:32]  <= apb_req_i.pwdata[15:0];
                `UDP_TX_REG_HOST_IP:      cfg_q.host_ip          <= apb_req_i.pwdata;
                `UDP_TX_REG_HOST_PORT:    cfg_q.host_port        <= apb_req_i.pwdata[15:0];
                `UDP_TX_REG_PAYLOAD_LEN: begin
                    cfg_q.payload_len <= apb_req_i.pwdata[`UDP_TX_LEN_W-1:0];
                end
                default: ;
            endcase
        end
    end

    // zero wait states, unmapped reads give zero
    assign apb_rsp_o.pready  = access;
    assign apb_rsp_o.pslverr = access && !addr_hit;
    assign apb_rsp_o.prdata  = (access && !apb_req_i.pwrite) ? rdata : 32'h0;

    assign cfg_o = cfg_q;

    // access phase must follow a setup phase
    a_apb_setup: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(apb_req_i.penable) |-> $past(apb_req_i.psel));

endmodule

//--- rtl/udp_header_builder.sv
`include "udp_tx_params.svh"

module udp_header_builder
    import udp_tx_pkg::*;
(
    input  udp_tx_cfg_t     cfg_i,
    output eth_udp_header_t header_o
);

    eth_udp_header_t hdr;
    logic [15:0]     payload_len16;
    logic [19:0]     csum_sum;
    logic [16:0]     csum_fold1;
    logic [15:0]     csum_fold2;

    assign payload_len16 = 16'(cfg_i.payload_len);

    // everything except the checksum, which stays zero here
    always_comb begin
        hdr            = '0;
        hdr.dst_mac    = cfg_i.host_mac;
        hdr.src_mac    = cfg_i.local_mac;
        hdr.ethertype  = 16'h0800;
        hdr.ver_ihl    = 8'h45;
        hdr.total_len  = payload_len16 + 16'd28;
        // don't fragment
        hdr.flags_frag = 16'h4000;
        hdr.ttl        = `UDP_TX_TTL;
        hdr.protocol   = 8'd17;
        hdr.src_ip     = cfg_i.local_ip;
        hdr.dst_ip     = cfg_i.host_ip;
        hdr.src_port   = cfg_i.local_port;
        hdr.dst_port   = cfg_i.host_port;
        hdr.udp_len    = payload_len16 + 16'd8;
    end

    // ones' complement sum of the ten ip halfwords
    assign csum_sum = 20'({hdr.ver_ihl, hdr.tos})
                    + 20'(hdr.total_len)
                    + 20'(hdr.id)
                    + 20'(hdr.flags_frag)
                    + 20'({hdr.ttl, hdr.protocol})
                    + 20'(hdr.ip_checksum)
                    + 20'(hdr.src_ip[31:16])
                    + 20'(hdr.src_ip[15:0])
                    + 20'(hdr.dst_ip[31:16])
                    + 20'(hdr.dst_ip[15:0]);

    // end-around carry, two folds are enough for ten terms
    assign csum_fold1 = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
    assign csum_fold2 = csum_fold1[15:0] + 16'(csum_fold1[16]);

    always_comb begin
        header_o             = hdr;
        header_o.ip_checksum = ~csum_fold2;
    end

endmodule

//--- rtl/payload_fifo.sv
`include "udp_tx_params.svh"

module payload_fifo (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    push_i,
    input  logic                    pop_i,
    input  logic [7:0]              data_i,
    output logic [7:0]              data_o,
    output logic [`UDP_TX_LEN_W:0]  count_o
);

    localparam int DEPTH = `UDP_TX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [7:0]             mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [PTR_W-1:0]       rd_ptr_q;
    logic [`UDP_TX_LEN_W:0] count_q;

    // power-of-two depth, pointers wrap on their own
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= data_i;
        end
        if (pop_i) begin
            data_o <= mem[rd_ptr_q];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else begin
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign count_o = count_q;

    // admission in the sequencer keeps these from firing
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> count_q != DEPTH);
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> count_q != 0);

endmodule

//--- rtl/eth_fcs_crc32.sv
module eth_fcs_crc32 (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] fcs_o
);

    // 0x04C11DB7 bit-reversed
    localparam logic [31:0] POLY_REFL = 32'hEDB88320;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // one byte, lsb first
    always_comb begin
        crc_next = crc_q ^ {24'h000000, data_i};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ POLY_REFL;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    // low byte goes on the wire first
    assign fcs_o = ~crc_q;

endmodule

//--- rtl/udp_frame_sequencer.sv
`include "udp_tx_params.svh"

module udp_frame_sequencer
    import udp_tx_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  udp_tx_cfg_t            cfg_i,
    input  eth_udp_header_t        header_i,
    input  logic [7:0]             s_data_i,
    input  logic                   s_valid_i,
    input  logic                   s_last_i,
    output logic                   s_ready_o,
    output logic                   push_o,
    output logic                   pop_o,
    output logic [7:0]             wdata_o,
    input  logic [7:0]             rdata_i,
    input  logic [`UDP_TX_LEN_W:0] count_i,
    output logic                   crc_clear_o,
    output logic                   crc_en_o,
    output logic [7:0]             crc_data_o,
    input  logic [31:0]            fcs_i,
    output logic                   tx_en_o,
    output logic [7:0]             tx_d_o
);

    localparam int CNT_W = 16;
    localparam int OCC_W = `UDP_TX_LEN_W + 2;
    localparam int HDR_W = $bits(eth_udp_header_t);
    localparam logic [CNT_W-1:0] PRE_LAST = CNT_W'(`UDP_TX_PREAMBLE_BYTES - 1);
    localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(`UDP_TX_HDR_BYTES - 1);
    localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(`UDP_TX_GAP_BYTES - 1);
    localparam logic [CNT_W-1:0] FCS_LAST = CNT_W'(3);
    // preamble, sfd, header and fcs around the payload
    localparam logic [CNT_W-1:0] FRAME_EXTRA =
        CNT_W'(`UDP_TX_PREAMBLE_BYTES + 1 + `UDP_TX_HDR_BYTES + 4);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_SFD,
        ST_HEADER,
        ST_DATA,
        ST_FCS,
        ST_GAP
    } seq_state_t;

    logic             s_handshake;
    logic             s_first_q;
    logic             s_in_pkt_q;
    logic [OCC_W-1:0] occ_after;
    logic             fifo_has_space;

    seq_state_t        state_q;
    seq_state_t        state_d;
    logic [CNT_W-1:0]  cnt_q;
    logic [CNT_W-1:0]  data_last;
    logic [`UDP_TX_LEN_W-1:0] len_q;
    logic [HDR_W-1:0]  hdr_sh_q;
    logic              frame_go;
    logic              tx_valid;
    logic [7:0]        tx_data;
    logic [CNT_W-1:0]  run_q;

    // stream intake, a packet is admitted only with room for all of it
    assign s_handshake    = s_valid_i && s_ready_o;
    assign occ_after      = OCC_W'(count_i) + OCC_W'(cfg_i.payload_len);
    assign fifo_has_space = occ_after <= OCC_W'(`UDP_TX_FIFO_DEPTH);
    assign s_ready_o      = (s_first_q && fifo_has_space) || s_in_pkt_q;
    assign push_o         = s_handshake;
    assign wdata_o        = s_data_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s_first_q  <= 1'b1;
            s_in_pkt_q <= 1'b0;
        end else if (s_handshake) begin
            s_first_q <= s_last_i;
            if (s_last_i) begin
                s_in_pkt_q <= 1'b0;
            end else if (s_first_q) begin
                s_in_pkt_q <= 1'b1;
            end
        end
    end

    // a whole payload must be buffered before the burst starts
    assign frame_go  = (count_i >= {1'b0, cfg_i.payload_len}) && (cfg_i.payload_len != '0);
    assign data_last = CNT_W'(len_q) - 1'b1;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:     if (frame_go)              state_d = ST_PREAMBLE;
            ST_PREAMBLE: if (cnt_q == PRE_LAST)     state_d = ST_SFD;
            ST_SFD:                                 state_d = ST_HEADER;
            ST_HEADER:   if (cnt_q == HDR_LAST)     state_d = ST_DATA;
            ST_DATA:     if (cnt_q == data_last)    state_d = ST_FCS;
            ST_FCS:      if (cnt_q == FCS_LAST)     state_d = ST_GAP;
            ST_GAP:      if (cnt_q == GAP_LAST)     state_d = ST_IDLE;
            default:                                state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            len_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= (state_d != state_q) ? '0 : cnt_q + 1'b1;
            // length frozen for the whole frame
            if (state_q == ST_IDLE) begin
                len_q <= cfg_i.payload_len;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE) begin
            hdr_sh_q <= header_i;
        end else if (state_q == ST_HEADER) begin
            hdr_sh_q <= hdr_sh_q << 8;
        end
    end

    // fifo data lags pop by one, so the first pop is on the last header byte
    always_comb begin
        tx_valid    = 1'b1;
        tx_data     = 8'h00;
        crc_en_o    = 1'b0;
        crc_clear_o = 1'b0;
        pop_o       = 1'b0;
        case (state_q)
            ST_IDLE: begin
                tx_valid    = 1'b0;
                crc_clear_o = 1'b1;
            end
            ST_PREAMBLE: tx_data = 8'h55;
            ST_SFD:      tx_data = 8'hD5;
            ST_HEADER: begin
                tx_data  = hdr_sh_q[HDR_W-1 -: 8];
                crc_en_o = 1'b1;
                pop_o    = (cnt_q == HDR_LAST);
            end
            ST_DATA: begin
                tx_data  = rdata_i;
                crc_en_o = 1'b1;
                pop_o    = (cnt_q != data_last);
            end
            // crc holds still here
            ST_FCS:  tx_data = fcs_i[8*cnt_q[1:0] +: 8];
            default: tx_valid = 1'b0;
        endcase
    end

    assign crc_data_o = tx_data;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_en_o <= 1'b0;
        end else begin
            tx_en_o <= tx_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        tx_d_o <= tx_data;
    end

    // length of the current tx_en_o burst
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_q <= '0;
        end else if (tx_en_o) begin
            run_q <= run_q + 1'b1;
        end else begin
            run_q <= '0;
        end
    end

    a_frame_len: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(tx_en_o) |-> run_q == CNT_W'(len_q) + FRAME_EXTRA);

endmodule

//--- rtl/udp_tx_top.sv
`include "udp_tx_params.svh"

module udp_tx_top
    import udp_tx_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  apb_req_t   apb_req_i,
    output apb_rsp_t   apb_rsp_o,
    input  logic [7:0] s_data_i,
    input  logic       s_valid_i,
    input  logic       s_last_i,
    output logic       s_ready_o,
    output logic       tx_en_o,
    output logic [7:0] tx_d_o
);

    udp_tx_cfg_t            cfg;
    eth_udp_header_t        header;
    logic                   fifo_push;
    logic                   fifo_pop;
    logic [7:0]             fifo_wdata;
    logic [7:0]             fifo_rdata;
    logic [`UDP_TX_LEN_W:0] fifo_count;
    logic                   crc_clear;
    logic                   crc_en;
    logic [7:0]             crc_data;
    logic [31:0]            fcs;

    udp_cfg_regs u_cfg_regs (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .apb_req_i(apb_req_i),
        .apb_rsp_o(apb_rsp_o),
        .cfg_o    (cfg)
    );

    udp_header_builder u_header_builder (
        .cfg_i   (cfg),
        .header_o(header)
    );

    payload_fifo u_payload_fifo (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (fifo_push),
        .pop_i  (fifo_pop),
        .data_i (fifo_wdata),
        .data_o (fifo_rdata),
        .count_o(fifo_count)
    );

    eth_fcs_crc32 u_fcs (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(crc_clear),
        .en_i   (crc_en),
        .data_i (crc_data),
        .fcs_o  (fcs)
    );

    udp_frame_sequencer u_sequencer (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cfg_i      (cfg),
        .header_i   (header),
        .s_data_i   (s_data_i),
        .s_valid_i  (s_valid_i),
        .s_last_i   (s_last_i),
        .s_ready_o  (s_ready_o),
        .push_o     (fifo_push),
        .pop_o      (fifo_pop),
        .wdata_o    (fifo_wdata),
        .rdata_i    (fifo_rdata),
        .count_i    (fifo_count),
        .crc_clear_o(crc_clear),
        .crc_en_o   (crc_en),
        .crc_data_o (crc_data),
        .fcs_i      (fcs),
        .tx_en_o    (tx_en_o),
        .tx_d_o     (tx_d_o)
    );

endmodule

//--- verification/udp_tx_tb.sv
`include "udp_tx_params.svh"

module udp_tx_tb
    import udp_tx_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT  = 4000;
    localparam int STALL_LIMIT = 5000;
    localparam int FRAME_LIMIT = 2100;
    localparam int REG_COUNT   = 9;
    localparam int MIN_GAP     = 12;

    logic       clk_i;
    logic       rst_i;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic [7:0] s_data;
    logic       s_valid;
    logic       s_last;
    logic       s_ready;
    logic       tx_en;
    logic [7:0] tx_d;

    // expected endpoint settings, kept in step with every register write
    logic [47:0] cfg_local_mac;
    logic [31:0] cfg_local_ip;
    logic [15:0] cfg_local_port;
    logic [47:0] cfg_host_mac;
    logic [31:0] cfg_host_ip;
    logic [15:0] cfg_host_port;
    int          cfg_len;

    logic [7:0]  payload_mem [0:4095];
    logic [7:0]  exp_q [$];
    logic [7:0]  cap_q [$];
    logic [15:0] lfsr_state;
    int          first_stall [3];
    bit          last_ok;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    udp_tx_top DUT (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .apb_req_i(apb_req),
        .apb_rsp_o(apb_rsp),
        .s_data_i (s_data),
        .s_valid_i(s_valid),
        .s_last_i (s_last),
        .s_ready_o(s_ready),
        .tx_en_o  (tx_en),
        .tx_d_o   (tx_d)
    );

    always #50 clk_i = ~clk_i;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic fill_payload(input int base, input int len);
        logic [7:0] v;
        for (int i = 0; i < len; i++) begin
            v = '0;
            for (int b = 0; b < 8; b++) begin
                lfsr_state = lfsr_next(lfsr_state);
                v = {v[6:0], lfsr_state[0]};
            end
            payload_mem[base + i] = v;
        end
    endtask

    // bitwise reflected crc-32, data lsb first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ d[b];
            c = c >> 1;
            if (fb) begin
                c = c ^ 32'hEDB88320;
            end
        end
        return c;
    endfunction

    function automatic logic [31:0] reg_mask(input logic [5:0] addr);
        case (addr)
            `UDP_TX_REG_LOCAL_MAC_HI, `UDP_TX_REG_HOST_MAC_HI: return 32'h0000FFFF;
            `UDP_TX_REG_LOCAL_PORT, `UDP_TX_REG_HOST_PORT:     return 32'h0000FFFF;
            `UDP_TX_REG_PAYLOAD_LEN: return (32'h1 << `UDP_TX_LEN_W) - 1;
            default: return 32'hFFFFFFFF;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        last_ok = (exp === act);
        if (!last_ok) begin
            errors++;
            test_errors++;
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic abort_run(input string why);
        $display("error: %s", why);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // setup cycle, then access cycle held until pready
    task automatic apb_transfer(input logic write, input logic [5:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        @(posedge clk_i);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk_i);
        #1;
        apb_req.penable = 1'b1;
        waited = 0;
        @(negedge clk_i);
        while (!apb_rsp.pready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("the APB slave never raised pready");
            end
            @(negedge clk_i);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk_i);
        #1;
        apb_req = '0;
    endtask

    task automatic reg_write(input logic [5:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_transfer(1'b1, addr, data, rd, err);
        check_value($sformatf("write 0x%0h pslverr", addr), 0, err);
    endtask

    task automatic apply_config();
        reg_write(`UDP_TX_REG_LOCAL_MAC_LO, cfg_local_mac[31:0]);
        reg_write(`UDP_TX_REG_LOCAL_MAC_HI, {16'h0000, cfg_local_mac[47:32]});
        reg_write(`UDP_TX_REG_LOCAL_IP, cfg_local_ip);
        reg_write(`UDP_TX_REG_LOCAL_PORT, {16'h0000, cfg_local_port});
        reg_write(`UDP_TX_REG_HOST_MAC_LO, cfg_host_mac[31:0]);
        reg_write(`UDP_TX_REG_HOST_MAC_HI, {16'h0000, cfg_host_mac[47:32]});
        reg_write(`UDP_TX_REG_HOST_IP, cfg_host_ip);
        reg_write(`UDP_TX_REG_HOST_PORT, {16'h0000, cfg_host_port});
        reg_write(`UDP_TX_REG_PAYLOAD_LEN, 32'(cfg_len));
    endtask

    // called 1 ns after a rising edge, returns at the same point
    task automatic send_packet(input int base, input int len, output int stall);
        int waited;
        stall = 0;
        for (int i = 0; i < len; i++) begin
            s_valid = 1'b1;
            s_data  = payload_mem[base + i];
            s_last  = (i == len - 1);
            waited  = 0;
            @(negedge clk_i);
            while (!s_ready) begin
                waited++;
                if (waited > STALL_LIMIT) begin
                    abort_run("the payload stream was never accepted");
                end
                @(negedge clk_i);
            end
            if (i == 0) begin
                stall = waited;
            end
            @(posedge clk_i);
            #1;
        end
        s_valid = 1'b0;
        s_last  = 1'b0;
    endtask

    // records one burst, gap counts the low samples seen before it
    task automatic capture_frame(output int gap);
        cap_q.delete();
        gap = 0;
        @(negedge clk_i);
        while (!tx_en) begin
            gap++;
            if (gap > WAIT_LIMIT) begin
                abort_run("no frame started on tx_en_o");
            end
            @(negedge clk_i);
        end
        while (tx_en) begin
            cap_q.push_back(tx_d);
            if (cap_q.size() > FRAME_LIMIT) begin
                abort_run("tx_en_o stayed high far longer than a frame");
            end
            @(negedge clk_i);
        end
    endtask

    task automatic build_frame(input int base, input int len);
        logic [7:0]  h [0:41];
        logic [31:0] sum;
        logic [31:0] crc;
        logic [15:0] csum;
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        ip_len  = 16'(len + 28);
        udp_len = 16'(len + 8);
        for (int i = 0; i < 6; i++) begin
            h[i]     = cfg_host_mac[47 - 8 * i -: 8];
            h[6 + i] = cfg_local_mac[47 - 8 * i -: 8];
        end
        h[12] = 8'h08;
        h[13] = 8'h00;
        h[14] = 8'h45;
        h[15] = 8'h00;
        h[16] = ip_len[15:8];
        h[17] = ip_len[7:0];
        h[18] = 8'h00;
        h[19] = 8'h00;
        h[20] = 8'h40;
        h[21] = 8'h00;
        h[22] = 8'd64;
        h[23] = 8'd17;
        h[24] = 8'h00;
        h[25] = 8'h00;
        for (int i = 0; i < 4; i++) begin
            h[26 + i] = cfg_local_ip[31 - 8 * i -: 8];
            h[30 + i] = cfg_host_ip[31 - 8 * i -: 8];
        end
        h[34] = cfg_local_port[15:8];
        h[35] = cfg_local_port[7:0];
        h[36] = cfg_host_port[15:8];
        h[37] = cfg_host_port[7:0];
        h[38] = udp_len[15:8];
        h[39] = udp_len[7:0];
        h[40] = 8'h00;
        h[41] = 8'h00;
        // ipv4 header spans bytes 14 to 33
        sum = 0;
        for (int i = 14; i < 34; i += 2) begin
            sum = sum + {h[i], h[i + 1]};
        end
        while (sum[31:16] != 0) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        csum  = ~sum[15:0];
        h[24] = csum[15:8];
        h[25] = csum[7:0];
        exp_q.delete();
        repeat (7) begin
            exp_q.push_back(8'h55);
        end
        exp_q.push_back(8'hD5);
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < 42; i++) begin
            exp_q.push_back(h[i]);
            crc = crc32_byte(crc, h[i]);
        end
        for (int i = 0; i < len; i++) begin
            exp_q.push_back(payload_mem[base + i]);
            crc = crc32_byte(crc, payload_mem[base + i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(crc[8 * i +: 8]);
        end
    endtask

    // stops at the first wrong byte
    task automatic compare_frame(input string name, input int base, input int len);
        build_frame(base, len);
        check_value({name, " length"}, exp_q.size(), cap_q.size());
        for (int i = 0; i < exp_q.size() && i < cap_q.size(); i++) begin
            check_value($sformatf("%s byte %0d", name, i), exp_q[i], cap_q[i]);
            if (!last_ok) begin
                break;
            end
        end
    endtask

    task automatic run_three(input int len, input string name);
        @(posedge clk_i);
        #1;
        fill_payload(0, 3 * len);
        fork
            begin
                for (int k = 0; k < 3; k++) begin
                    send_packet(k * len, len, first_stall[k]);
                end
            end
            begin
                int gap;
                for (int k = 0; k < 3; k++) begin
                    capture_frame(gap);
                    compare_frame($sformatf("%s frame %0d", name, k), k * len, len);
                    // the sample that ended the previous burst was low as well
                    if (k > 0) begin
                        check_value($sformatf("%s gap before frame %0d", name, k), 1,
                                    gap + 1 >= MIN_GAP);
                    end
                end
            end
        join
    endtask

    task automatic test_register_access();
        logic [31:0] rd;
        logic        err;
        logic [31:0] pattern;
        logic [5:0]  addr;
        check_value("reset tx_en_o", 0, tx_en);
        check_value("reset s_ready_o", 1, s_ready);
        check_value("reset pready", 0, apb_rsp.pready);
        check_value("reset pslverr", 0, apb_rsp.pslverr);
        for (int a = 0; a < REG_COUNT; a++) begin
            apb_transfer(1'b0, 6'(a), 32'h0, rd, err);
            check_value($sformatf("reg %0d after reset", a), 0, rd);
        end
        for (int pass = 0; pass < 2; pass++) begin
            for (int a = 0; a < REG_COUNT; a++) begin
                pattern = (pass == 0) ? 32'hFFFFFFFF : 32'h13579BDF ^ (32'(a) * 32'h01010101);
                reg_write(6'(a), pattern);
                apb_transfer(1'b0, 6'(a), 32'h0, rd, err);
                check_value($sformatf("reg %0d readback", a), pattern & reg_mask(6'(a)), rd);
                check_value($sformatf("reg %0d read pslverr", a), 0, err);
            end
        end
        for (int k = 0; k < 2; k++) begin
            addr = (k == 0) ? 6'h09 : 6'h3F;
            apb_transfer(1'b1, addr, 32'hFFFFFFFF, rd, err);
            check_value($sformatf("unmapped 0x%0h write pslverr", addr), 1, err);
            apb_transfer(1'b0, addr, 32'h0, rd, err);
            check_value($sformatf("unmapped 0x%0h read pslverr", addr), 1, err);
            check_value($sformatf("unmapped 0x%0h read data", addr), 0, rd);
        end
        end_test("register_access");
    endtask

    task automatic test_single_frame();
        int stall;
        int gap;
        cfg_local_mac  = 48'h020000000001;
        cfg_local_ip   = 32'hC0A80164;
        cfg_local_port = 16'd5000;
        cfg_host_mac   = 48'h001B213C4D5E;
        cfg_host_ip    = 32'hC0A80101;
        cfg_host_port  = 16'd6000;
        cfg_len        = 64;
        apply_config();
        fill_payload(0, cfg_len);
        fork
            send_packet(0, cfg_len, stall);
            capture_frame(gap);
        join
        check_value("single frame burst length", 118, cap_q.size());
        compare_frame("single frame", 0, cfg_len);
        end_test("single_frame");
    endtask

    task automatic test_back_to_back();
        run_three(cfg_len, "back_to_back");
        end_test("back_to_back");
    endtask

    // fifo holds two packets of 1000, the third must wait for the first frame
    task automatic test_back_pressure();
        cfg_len = 1000;
        reg_write(`UDP_TX_REG_PAYLOAD_LEN, 32'(cfg_len));
        run_three(cfg_len, "back_pressure");
        check_value("first packet accepted at once", 0, first_stall[0]);
        check_value("third packet held off", 1, first_stall[2] > 0);
        end_test("back_pressure");
    endtask

    task automatic test_reconfiguration();
        int stall;
        int gap;
        cfg_host_ip   = 32'h0A000002;
        cfg_host_port = 16'd7001;
        cfg_len       = 200;
        reg_write(`UDP_TX_REG_HOST_IP, cfg_host_ip);
        reg_write(`UDP_TX_REG_HOST_PORT, {16'h0000, cfg_host_port});
        reg_write(`UDP_TX_REG_PAYLOAD_LEN, 32'(cfg_len));
        fill_payload(0, cfg_len);
        fork
            send_packet(0, cfg_len, stall);
            capture_frame(gap);
        join
        check_value("reconfigured burst length", 254, cap_q.size());
        compare_frame("reconfigured frame", 0, cfg_len);
        end_test("reconfiguration");
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        apb_req      = '0;
        s_data       = 8'h00;
        s_valid      = 1'b0;
        s_last       = 1'b0;
        lfsr_state   = 16'd35;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        test_register_access();
        test_single_frame();
        test_back_to_back();
        test_back_pressure();
        test_reconfiguration();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/udp_tx_pkg.sv
rtl/udp_cfg_regs.sv
rtl/udp_header_builder.sv
rtl/payload_fifo.sv
rtl/eth_fcs_crc32.sv
rtl/udp_frame_sequencer.sv
rtl/udp_tx_top.sv
verification/udp_tx_tb.sv
